//--- src.f
design/vdp_bus_pkg.sv
design/vdp_reg_pkg.sv
design/msx_slot.sv
design/vdp_io_port.sv
design/vram_ctrl.sv
design/vdp_cartridge.sv
dv/tb_vdp_cartridge.sv

//--- Makefile
TOP = tb_vdp_cartridge

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- dv/tb_vdp_cartridge.sv
// VDP cartridge testbench
`timescale 1ns/1ns

module tb_vdp_cartridge;

	localparam int         init_cycles = 64;
	localparam int         wait_limit  = init_cycles + 64;	// slot_wait timeout
	localparam int         drain_limit = 100;
	localparam logic [7:0] data_addr   = vdp_bus_pkg::vdp_port_base;	// port 0
	localparam logic [7:0] ctrl_addr   = vdp_bus_pkg::vdp_port_base + 8'd1;	// port 1
	localparam logic [7:0] ind_addr    = vdp_bus_pkg::vdp_port_base + 8'd3;	// port 3
	localparam logic [7:0] far_addr    = 8'h98;	// outside the VDP range

	logic       clk;
	logic       reset;
	logic       slot_iorq_n;
	logic       slot_rd_n;
	logic       slot_wr_n;
	logic [7:0] slot_a;
	wire  [7:0] slot_d;
	logic [7:0] slot_dout;		// CPU side of the data bus
	logic       slot_drive;
	logic       slot_data_dir;
	logic       slot_wait;
	logic       slot_intr;

	// ----------------------------------------
	// reference model state
	// ----------------------------------------
	logic [7:0]  ref_mem [0:131071];	// 128 KB VRAM image
	logic [7:0]  ref_reg [0:63];		// r#14 bank, r#15 status, r#17 indirect
	logic [13:0] ref_cnt;			// A13..A0
	logic [16:0] ref_buf_addr;		// address held in the read-ahead
	logic        ref_toggle;		// second control byte expected
	logic [7:0]  ref_first;

	logic [7:0] got_q [$];		// reads waiting for compare
	logic [7:0] exp_q [$];
	string      name_q [$];
	int         seed;

	initial clk = 1'b0;
	always #10 clk = ~clk;	// 20 ns period

	assign slot_d = slot_drive ? slot_dout : 8'hzz;

	vdp_cartridge #(
		.init_cycles (init_cycles)
	) u_vdp_cartridge (
		.clk           (clk),
		.reset         (reset),
		.slot_iorq_n   (slot_iorq_n),
		.slot_rd_n     (slot_rd_n),
		.slot_wr_n     (slot_wr_n),
		.slot_a        (slot_a),
		.slot_d        (slot_d),
		.slot_data_dir (slot_data_dir),
		.slot_wait     (slot_wait),
		.slot_intr     (slot_intr)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "run stopped");
	endtask

	function automatic logic [7:0] ref_vram_read(input logic [16:0] addr);
		return ref_mem[addr];
	endfunction

	// counter carries into r#14, wraps at 128K
	task automatic step_model_addr();
		logic [16:0] nxt_addr;
		nxt_addr = {ref_reg[14][2:0], ref_cnt} + 17'd1;
		ref_cnt = nxt_addr[13:0];
		ref_reg[14][2:0] = nxt_addr[16:14];
	endtask

	task automatic queue_check(input string name, input logic [7:0] exp, input logic [7:0] got);
		name_q.push_back(name);
		exp_q.push_back(exp);
		got_q.push_back(got);
	endtask

	// ----------------------------------------
	// slot cycles
	// ----------------------------------------
	task automatic io_write(input logic [7:0] addr, input logic [7:0] data);
		@(posedge clk);
		#2;
		slot_a      = addr;
		slot_dout   = data;
		slot_drive  = 1'b1;
		slot_iorq_n = 1'b0;
		slot_wr_n   = 1'b0;
		repeat (12) @(posedge clk);	// strobe low for 12 cycles
		#2;
		slot_iorq_n = 1'b1;
		slot_wr_n   = 1'b1;
		slot_drive  = 1'b0;
		repeat (3) @(posedge clk);	// bus idle between cycles
	endtask

	task automatic io_read(input logic [7:0] addr, input logic hit, output logic [7:0] data);
		@(posedge clk);
		#2;
		slot_a      = addr;
		slot_iorq_n = 1'b0;
		slot_rd_n   = 1'b0;
		for (int i = 0; i < 12; i++) begin
			@(posedge clk);
			#2;
			if (!hit) begin
				assert (slot_data_dir === 1'b0)
				else abort_run("data direction rose during a read outside the VDP ports");
			end
		end
		if (hit) begin
			assert (slot_data_dir === 1'b1)
			else abort_run("data direction low at the end of a VDP port read");
		end
		data        = slot_d;	// sampled just before rd rises
		slot_iorq_n = 1'b1;
		slot_rd_n   = 1'b1;
		repeat (3) @(posedge clk);
	endtask

	// ----------------------------------------
	// VDP accesses with model update
	// ----------------------------------------
	task automatic ctrl_write(input logic [7:0] b);
		io_write(ctrl_addr, b);
		if (!ref_toggle) begin
			ref_first = b;
		end else if (b[7]) begin
			ref_reg[b[5:0]] = ref_first;	// register write
		end else begin
			ref_cnt = {b[5:0], ref_first};	// address set
			if (!b[6]) begin
				ref_buf_addr = {ref_reg[14][2:0], ref_cnt};	// read setup prefetch
				step_model_addr();
			end
		end
		ref_toggle = ~ref_toggle;
	endtask

	task automatic reg_write(input logic [7:0] num, input logic [7:0] val);
		ctrl_write(val);
		ctrl_write(8'h80 | num);
	endtask

	task automatic set_write_addr(input logic [13:0] addr);
		ctrl_write(addr[7:0]);
		ctrl_write({2'b01, addr[13:8]});
	endtask

	task automatic set_read_addr(input logic [13:0] addr);
		ctrl_write(addr[7:0]);
		ctrl_write({2'b00, addr[13:8]});
	endtask

	task automatic data_write(input logic [7:0] b);
		io_write(data_addr, b);
		ref_mem[{ref_reg[14][2:0], ref_cnt}] = b;
		step_model_addr();
	endtask

	task automatic data_read(input string name);
		logic [7:0] got;
		io_read(data_addr, 1'b1, got);
		queue_check(name, ref_vram_read(ref_buf_addr), got);
		ref_buf_addr = {ref_reg[14][2:0], ref_cnt};	// refill from next address
		step_model_addr();
	endtask

	task automatic status_read(input string name);
		logic [7:0] got;
		logic [7:0] exp;
		io_read(ctrl_addr, 1'b1, got);
		exp = (ref_reg[15][3:0] == 4'd1) ? 8'h04 : 8'h00;	// only S#1 implemented
		queue_check(name, exp, got);
		ref_toggle = 1'b0;
	endtask

	task automatic indirect_write(input logic [7:0] b);
		logic [5:0] ptr;
		ptr = ref_reg[17][5:0];
		io_write(ind_addr, b);
		ref_reg[ptr] = b;
		if (!ref_reg[17][7]) begin
			ref_reg[17][5:0] = ptr + 6'd1;
		end
	endtask

	// compare process
	always @(posedge clk) begin
		logic [7:0] got;
		logic [7:0] exp;
		string      name;
		assert (slot_intr === 1'b0)
		else abort_run("slot interrupt line went active");
		if (got_q.size() > 0) begin
			got  = got_q.pop_front();
			exp  = exp_q.pop_front();
			name = name_q.pop_front();
			assert (got === exp)
			else abort_run($sformatf("Fail %s expected %02h actual %02h", name, exp, got));
		end
	end

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		logic [7:0] far_data;
		int         waited;
		seed        = 32'hddec2cd5;
		reset       = 1'b1;
		slot_iorq_n = 1'b1;
		slot_rd_n   = 1'b1;
		slot_wr_n   = 1'b1;
		slot_a      = 8'h00;
		slot_dout   = 8'h00;
		slot_drive  = 1'b0;
		ref_cnt      = '0;
		ref_buf_addr = '0;
		ref_toggle   = 1'b0;
		ref_first    = 8'h00;
		for (int i = 0; i < 64; i++) begin
			ref_reg[i] = 8'h00;
		end
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;

		// init period holds the slot
		assert (slot_wait === 1'b1) else abort_run("slot_wait not high after reset");
		waited = 0;
		while (slot_wait !== 1'b0) begin
			@(posedge clk);
			#2;
			waited++;
			if (waited > wait_limit) begin
				abort_run("timeout waiting for slot_wait to fall after init");
			end
		end

		// data port round trip, with a foreign read in the middle
		set_write_addr(14'h0100);
		for (int i = 0; i < 64; i++) begin
			data_write(8'($random(seed)));
		end
		set_read_addr(14'h0100);
		for (int i = 0; i < 32; i++) begin
			data_read("data_rw");
		end
		io_read(far_addr, 1'b0, far_data);	// must not move the counter
		for (int i = 32; i < 64; i++) begin
			data_read("data_rw_after_far");
		end

		// top bank through r#17 -> r#14, same offset as the bank 0 data
		reg_write(8'd17, 8'd14);
		indirect_write(8'h07);
		set_write_addr(14'h0100);
		for (int i = 0; i < 16; i++) begin
			data_write(8'($random(seed)));
		end
		set_read_addr(14'h0100);
		for (int i = 0; i < 16; i++) begin
			data_read("bank7");
		end

		// 0x1fffc..0x00003, r#17 without increment
		reg_write(8'd17, 8'h8e);
		indirect_write(8'h07);
		set_write_addr(14'h3ffc);
		for (int i = 0; i < 8; i++) begin
			data_write(8'($random(seed)));
		end
		indirect_write(8'h07);	// counter wrapped r#14 to 0
		set_read_addr(14'h3ffc);
		for (int i = 0; i < 8; i++) begin
			data_read("wrap");
		end

		// status read resyncs a half control sequence
		reg_write(8'd15, 8'h01);
		ctrl_write(8'h5a);
		status_read("status_id");
		set_read_addr(14'h0100);
		for (int i = 0; i < 8; i++) begin
			data_read("after_status");
		end

		waited = 0;
		while (got_q.size() > 0) begin
			@(posedge clk);
			waited++;
			if (waited > drain_limit) begin
				abort_run("timeout waiting for the read compares to finish");
			end
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- design/vdp_cartridge.sv
// VDP cartridge top level
`timescale 1ns/1ns

module vdp_cartridge #(
	parameter int init_cycles = 4096
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       slot_iorq_n,
	input  logic       slot_rd_n,
	input  logic       slot_wr_n,
	input  logic [7:0] slot_a,
	inout  wire  [7:0] slot_d,
	output logic       slot_data_dir,
	output logic       slot_wait,
	output logic       slot_intr
);
	logic                   port_hit;	// slot_a in 0x88..0x8b
	logic                   bus_valid;
	vdp_bus_pkg::cpu_req_t  bus_req;
	logic [7:0]             rdata;
	logic                   rdata_en;
	logic                   vram_valid;
	vdp_bus_pkg::vram_req_t vram_req;
	logic                   vram_busy;
	logic [7:0]             vram_rdata;
	logic                   vram_rdata_en;

	assign port_hit  = (slot_a[7:2] == vdp_bus_pkg::vdp_port_base[7:2]);
	assign slot_intr = 1'b0;	// no interrupts

	// ----------------------------------------
	// slot front end
	// ----------------------------------------
	msx_slot u_msx_slot (
		.clk           (clk),
		.reset         (reset),
		.slot_iorq_n   (slot_iorq_n),
		.slot_rd_n     (slot_rd_n),
		.slot_wr_n     (slot_wr_n),
		.slot_a        (slot_a),
		.slot_d        (slot_d),
		.slot_data_dir (slot_data_dir),
		.slot_wait     (slot_wait),
		.busy          (vram_busy),
		.port_hit      (port_hit),
		.bus_valid     (bus_valid),
		.bus_req       (bus_req),
		.rdata         (rdata),
		.rdata_en      (rdata_en)
	);

	// ----------------------------------------
	// VDP ports
	// ----------------------------------------
	vdp_io_port u_vdp_io_port (
		.clk           (clk),
		.reset         (reset),
		.bus_valid     (bus_valid),
		.bus_req       (bus_req),
		.rdata         (rdata),
		.rdata_en      (rdata_en),
		.vram_valid    (vram_valid),
		.vram_req      (vram_req),
		.vram_busy     (vram_busy),
		.vram_rdata    (vram_rdata),
		.vram_rdata_en (vram_rdata_en)
	);

	// ----------------------------------------
	// VRAM
	// ----------------------------------------
	vram_ctrl #(
		.init_cycles (init_cycles)
	) u_vram_ctrl (
		.clk           (clk),
		.reset         (reset),
		.vram_valid    (vram_valid),
		.vram_req      (vram_req),
		.vram_busy     (vram_busy),
		.vram_rdata    (vram_rdata),
		.vram_rdata_en (vram_rdata_en)
	);

endmodule

//--- design/vram_ctrl.sv
// VRAM controller model
`timescale 1ns/1ns

module vram_ctrl #(
	parameter int init_cycles = 4096
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   vram_valid,
	input  vdp_bus_pkg::vram_req_t vram_req,
	output logic                   vram_busy,
	output logic [7:0]             vram_rdata,
	output logic                   vram_rdata_en
);
	localparam int init_w = $clog2(init_cycles + 1);

	logic [7:0]        mem [0:131071];	// 128K x 8
	logic [init_w-1:0] init_cnt;
	logic              init_busy;		// power-up period
	logic [7:0]        ref_cnt;		// 256-cycle refresh period
	logic              ref_busy;
	logic              accept;
	logic              rd_s1_valid;		// read pipe stage 1
	logic [7:0]        rd_s1_data;

	// ----------------------------------------
	// init and refresh timing
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			init_cnt  <= '0;
			init_busy <= 1'b1;
			ref_cnt   <= 8'd0;
		end else if (init_busy) begin
			init_cnt <= init_cnt + 1'b1;
			if (init_cnt == init_w'(init_cycles - 1)) begin
				init_busy <= 1'b0;
			end
		end else begin
			ref_cnt <= ref_cnt + 8'd1;
		end
	end

	assign ref_busy  = (ref_cnt[7:2] == 6'h3f);	// last 4 cycles of each period
	assign vram_busy = init_busy | ref_busy;
	assign accept    = vram_valid & ~vram_busy;

	// ----------------------------------------
	// memory array
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (accept && vram_req.write) begin
			mem[vram_req.addr] <= vram_req.wdata;
		end
		rd_s1_data <= mem[vram_req.addr];
		vram_rdata <= rd_s1_data;
	end

	// two reads may be in flight
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_s1_valid   <= 1'b0;
			vram_rdata_en <= 1'b0;
		end else begin
			rd_s1_valid   <= accept & ~vram_req.write;
			vram_rdata_en <= rd_s1_valid;
		end
	end

endmodule

//--- design/vdp_io_port.sv
// V9958 CPU port block
`timescale 1ns/1ns

module vdp_io_port (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   bus_valid,
	input  vdp_bus_pkg::cpu_req_t  bus_req,
	output logic [7:0]             rdata,
	output logic                   rdata_en,
	output logic                   vram_valid,
	output vdp_bus_pkg::vram_req_t vram_req,
	input  logic                   vram_busy,
	input  logic [7:0]             vram_rdata,
	input  logic                   vram_rdata_en
);
	logic [7:0]              vdp_reg [0:63];	// r#0..r#63
	logic [8:0]              palette [0:15];	// r3 b3 g3
	logic [13:0]             addr_cnt;		// A13..A0
	logic [7:0]              ctrl_first;		// first control byte
	logic                    ctrl_toggle;		// 1 = waiting for second byte
	logic [7:0]              pal_first;
	logic                    pal_toggle;
	logic [7:0]              rd_buf;		// read-ahead
	vdp_reg_pkg::ctrl_byte_u ctrl_byte;
	logic                    wr_data;
	logic                    rd_data;
	logic                    wr_ctrl;
	logic                    rd_ctrl;
	logic                    wr_pal;
	logic                    wr_ind;
	logic                    set_reg;
	logic                    set_addr;
	logic                    prefetch_set;
	logic                    do_access;
	logic [16:0]             acc_addr;
	logic [16:0]             acc_next;
	logic [5:0]              ind_ptr;
	logic [7:0]              status_val;

	// ----------------------------------------
	// request decode
	// ----------------------------------------
	assign wr_data = bus_valid & bus_req.write & (bus_req.port == vdp_bus_pkg::port_data);
	assign rd_data = bus_valid & ~bus_req.write & (bus_req.port == vdp_bus_pkg::port_data);
	assign wr_ctrl = bus_valid & bus_req.write & (bus_req.port == vdp_bus_pkg::port_ctrl);
	assign rd_ctrl = bus_valid & ~bus_req.write & (bus_req.port == vdp_bus_pkg::port_ctrl);
	assign wr_pal  = bus_valid & bus_req.write & (bus_req.port == vdp_bus_pkg::port_palette);
	assign wr_ind  = bus_valid & bus_req.write & (bus_req.port == vdp_bus_pkg::port_indirect);

	assign ctrl_byte    = bus_req.wdata;
	assign set_reg      = wr_ctrl & ctrl_toggle & ctrl_byte.reg_form.reg_flag;
	assign set_addr     = wr_ctrl & ctrl_toggle & ~ctrl_byte.addr_form.reg_flag;
	assign prefetch_set = set_addr & ~ctrl_byte.addr_form.write_mode;	// read setup

	assign ind_ptr = vdp_reg[vdp_reg_pkg::reg_indirect_ptr][5:0];

	// S#1 carries the id, the rest read as zero
	assign status_val = (vdp_reg[vdp_reg_pkg::reg_status_ptr][3:0] == vdp_reg_pkg::status_id_sel) ?
		vdp_reg_pkg::vdp_id_status : vdp_reg_pkg::status_none;

	// ----------------------------------------
	// vram address
	// ----------------------------------------
	always_comb begin
		acc_addr = {vdp_reg[vdp_reg_pkg::reg_bank_ptr][2:0], addr_cnt};
		if (prefetch_set) begin
			acc_addr = {vdp_reg[vdp_reg_pkg::reg_bank_ptr][2:0],
				ctrl_byte.addr_form.addr_hi, ctrl_first};
		end
	end

	assign acc_next  = acc_addr + 17'd1;	// carries into r#14, wraps at 128K
	assign do_access = wr_data | rd_data | prefetch_set;

	// ----------------------------------------
	// control state and registers
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 64; i++) begin
				vdp_reg[i] <= 8'h00;
			end
			addr_cnt    <= '0;
			ctrl_toggle <= 1'b0;
			pal_toggle  <= 1'b0;
			vram_valid  <= 1'b0;
			rdata_en    <= 1'b0;
		end else begin
			rdata_en <= bus_valid & ~bus_req.write;	// always answers next cycle
			if (vram_valid && !vram_busy) begin
				vram_valid <= 1'b0;	// accepted
			end
			if (do_access) begin
				vram_valid <= 1'b1;
				addr_cnt   <= acc_next[13:0];
				vdp_reg[vdp_reg_pkg::reg_bank_ptr][2:0] <= acc_next[16:14];
			end else if (set_addr) begin
				addr_cnt <= {ctrl_byte.addr_form.addr_hi, ctrl_first};	// write setup
			end
			if (wr_ctrl) begin
				ctrl_toggle <= ~ctrl_toggle;
			end else if (rd_ctrl) begin
				ctrl_toggle <= 1'b0;	// status read resyncs the sequence
			end
			if (set_reg) begin
				vdp_reg[ctrl_byte.reg_form.reg_num] <= ctrl_first;
			end
			if (wr_ind) begin
				vdp_reg[ind_ptr] <= bus_req.wdata;
				if (!vdp_reg[vdp_reg_pkg::reg_indirect_ptr][7]) begin
					vdp_reg[vdp_reg_pkg::reg_indirect_ptr][5:0] <= ind_ptr + 6'd1;
				end
			end
			if (wr_pal) begin
				pal_toggle <= ~pal_toggle;
				if (pal_toggle) begin
					vdp_reg[vdp_reg_pkg::reg_palette_ptr][3:0] <=
						vdp_reg[vdp_reg_pkg::reg_palette_ptr][3:0] + 4'd1;
				end
			end
		end
	end

	// ----------------------------------------
	// data path
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (wr_ctrl && !ctrl_toggle) begin
			ctrl_first <= bus_req.wdata;
		end
		if (wr_pal && !pal_toggle) begin
			pal_first <= bus_req.wdata;	// 0 r2 r1 r0 0 b2 b1 b0
		end
		if (wr_pal && pal_toggle) begin
			palette[vdp_reg[vdp_reg_pkg::reg_palette_ptr][3:0]] <=
				{pal_first[6:4], pal_first[2:0], bus_req.wdata[2:0]};
		end
		if (vram_rdata_en) begin
			rd_buf <= vram_rdata;	// prefetch fill
		end
		if (do_access) begin
			vram_req.addr  <= acc_addr;
			vram_req.write <= wr_data;
			vram_req.wdata <= bus_req.wdata;
		end
		if (bus_valid && !bus_req.write) begin
			case (bus_req.port)
				vdp_bus_pkg::port_data: rdata <= rd_buf;
				vdp_bus_pkg::port_ctrl: rdata <= status_val;
				default:                rdata <= 8'hff;	// write-only ports
			endcase
		end
	end

endmodule

//--- design/msx_slot.sv
// MSX slot front end
`timescale 1ns/1ns

module msx_slot (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  slot_iorq_n,
	input  logic                  slot_rd_n,
	input  logic                  slot_wr_n,
	input  logic [7:0]            slot_a,
	inout  wire  [7:0]            slot_d,
	output logic                  slot_data_dir,
	output logic                  slot_wait,
	input  logic                  busy,
	input  logic                  port_hit,
	output logic                  bus_valid,
	output vdp_bus_pkg::cpu_req_t bus_req,
	input  logic [7:0]            rdata,
	input  logic                  rdata_en
);
	logic [1:0] iorq_sync;		// [1] is the settled copy
	logic [1:0] rd_sync;
	logic [1:0] wr_sync;
	logic       rd_cycle;		// iorq & rd both low
	logic       wr_cycle;		// iorq & wr both low
	logic       rd_cycle_d;
	logic       wr_cycle_d;
	logic       rd_start;
	logic       wr_start;
	logic       rd_drive;		// our read cycle in progress
	logic       init_done;
	logic [7:0] rd_hold;		// byte returned to the CPU

	// ----------------------------------------
	// strobe synchroniser
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			iorq_sync <= 2'b11;
			rd_sync   <= 2'b11;
			wr_sync   <= 2'b11;
		end else begin
			iorq_sync <= {iorq_sync[0], slot_iorq_n};
			rd_sync   <= {rd_sync[0], slot_rd_n};
			wr_sync   <= {wr_sync[0], slot_wr_n};
		end
	end

	assign rd_cycle = ~iorq_sync[1] & ~rd_sync[1];
	assign wr_cycle = ~iorq_sync[1] & ~wr_sync[1];
	assign rd_start = rd_cycle & ~rd_cycle_d;	// falling edge only
	assign wr_start = wr_cycle & ~wr_cycle_d;

	// ----------------------------------------
	// bus request
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_cycle_d <= 1'b0;
			wr_cycle_d <= 1'b0;
			bus_valid  <= 1'b0;
			rd_drive   <= 1'b0;
			init_done  <= 1'b0;
		end else begin
			rd_cycle_d <= rd_cycle;
			wr_cycle_d <= wr_cycle;
			bus_valid  <= (rd_start | wr_start) & port_hit;	// one pulse per strobe
			rd_drive   <= rd_cycle & port_hit;
			if (!busy) begin
				init_done <= 1'b1;	// first idle cycle ends init
			end
		end
	end

	always_ff @(posedge clk) begin
		bus_req.port  <= slot_a[1:0];
		bus_req.write <= wr_start;
		bus_req.wdata <= slot_d;	// out data sampled at the edge
	end

	// ----------------------------------------
	// read return
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rd_start && port_hit) begin
			rd_hold <= 8'hff;	// idle bus value until data returns
		end else if (rdata_en) begin
			rd_hold <= rdata;
		end
	end

	assign slot_data_dir = rd_drive & ~slot_rd_n;	// drop as soon as rd rises
	assign slot_d        = slot_data_dir ? rd_hold : 8'hzz;

	// hold the CPU only while vram is still initialising
	assign slot_wait = busy & ~init_done;

endmodule

//--- design/vdp_reg_pkg.sv
// VDP register map and status
package vdp_reg_pkg;

	// ----------------------------------------
	// register numbers
	// ----------------------------------------
	localparam logic [5:0] reg_bank_ptr     = 6'd14;	// vram A16..A14
	localparam logic [5:0] reg_status_ptr   = 6'd15;	// status select
	localparam logic [5:0] reg_palette_ptr  = 6'd16;	// palette index
	localparam logic [5:0] reg_indirect_ptr = 6'd17;	// indirect target, bit7 = no inc

	// ----------------------------------------
	// second control byte
	// ----------------------------------------
	typedef struct packed {
		logic       reg_flag;	// 1 here
		logic       unused;
		logic [5:0] reg_num;	// target register
	} ctrl_reg_form_t;

	typedef struct packed {
		logic       reg_flag;	// 0 here
		logic       write_mode;	// 1 = write setup, 0 = read setup
		logic [5:0] addr_hi;	// A13..A8
	} ctrl_addr_form_t;

	// same byte, decoded by bit 7
	typedef union packed {
		ctrl_reg_form_t  reg_form;
		ctrl_addr_form_t addr_form;
	} ctrl_byte_u;

	// ----------------------------------------
	// status registers
	// ----------------------------------------
	localparam logic [3:0] status_id_sel = 4'd1;	// S#1
	localparam logic [7:0] vdp_id_status = 8'h04;	// V9958 id bits
	localparam logic [7:0] status_none   = 8'h00;	// unimplemented S#n

endpackage

//--- design/vdp_bus_pkg.sv
// CPU and VRAM bus types
package vdp_bus_pkg;

	// ----------------------------------------
	// VDP port map
	// ----------------------------------------
	localparam logic [7:0] vdp_port_base = 8'h88;	// ports 0x88..0x8b

	localparam logic [1:0] port_data     = 2'd0;	// vram data
	localparam logic [1:0] port_ctrl     = 2'd1;	// address / register set, status read
	localparam logic [1:0] port_palette  = 2'd2;	// two-byte palette write
	localparam logic [1:0] port_indirect = 2'd3;	// write through r#17

	// ----------------------------------------
	// internal I/O request
	// ----------------------------------------
	// one decoded I/O cycle, qualified by a separate valid strobe
	typedef struct packed {
		logic [1:0] port;	// slot_a[1:0]
		logic       write;	// 1 = out, 0 = in
		logic [7:0] wdata;	// out data, don't care on reads
	} cpu_req_t;

	// ----------------------------------------
	// VRAM access
	// ----------------------------------------
	// byte access into the 128 KB array
	typedef struct packed {
		logic [16:0] addr;	// r#14[2:0] & counter
		logic        write;
		logic [7:0]  wdata;
	} vram_req_t;

endpackage
